// File: all.f
+incdir+rtl
rtl/core_pkg.sv
rtl/gpr.sv
rtl/ifu.sv
rtl/idu.sv
rtl/exu.sv
rtl/core_top.sv
test/core_tb.sv

// File: Bender.yml
package:
  name: core

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/core_pkg.sv
      - rtl/gpr.sv
      - rtl/ifu.sv
      - rtl/idu.sv
      - rtl/exu.sv
      - rtl/core_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/core_tb.sv

// File: test/core_tb.sv
`timescale 1ns/10ps
`include "core_defines.svh"

module core_tb;

    localparam logic [31:0] SEED        = 32'h1cb2;
    localparam int          PROG_MAX    = 48;
    localparam int          RUN_TIMEOUT = 4000;
    localparam int          HALT_WINDOW = 40;
    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;
    // lw x5, 0(x0)
    localparam logic [31:0] LOAD_WORD   = 32'h0000_2283;

    logic        clk;
    logic        rst;
    logic        imem_req;
    logic [31:0] imem_addr;
    logic        imem_rvalid;
    logic [31:0] imem_rdata;
    logic        commit_valid;
    logic [31:0] commit_pc;
    logic [4:0]  commit_rd;
    logic        commit_we;
    logic [31:0] commit_data;
    logic        halted;
    logic        illegal;

    logic [31:0] prog [PROG_MAX];
    logic        is_target [PROG_MAX];
    int          prog_len;
    logic [31:0] ref_regs [32];
    logic [31:0] ref_pc;
    logic [31:0] fetch_addr;
    logic        fetch_check;
    logic        rvalid_seen;
    logic        halt_seen;
    logic        illegal_exp;
    logic        pending;
    int          wait_left;

    core_top u_dut (
        .clk          (clk),
        .rst          (rst),
        .imem_req     (imem_req),
        .imem_addr    (imem_addr),
        .imem_rvalid  (imem_rvalid),
        .imem_rdata   (imem_rdata),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_rd    (commit_rd),
        .commit_we    (commit_we),
        .commit_data  (commit_data),
        .halted       (halted),
        .illegal      (illegal)
    );

    always #50 clk = ~clk;

    task automatic fail_run(input string what);
        $display("%s", what);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else
            fail_run($sformatf("Mismatch %s: got %08h expected %08h", name, got, exp));
    endtask

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        if ((addr >> 2) < prog_len) begin
            return prog[addr >> 2];
        end
        return EBREAK_WORD;
    endfunction

    function automatic logic [31:0] alu(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    // Steps the ISA reference model once per commit
    task automatic step_model();
        logic [31:0] ins, a, b, imm_i, imm_b, imm_j, res, npc;
        logic [2:0]  f3;
        logic        wr, stop;
        ins   = mem_word(ref_pc);
        a     = ref_regs[ins[19:15]];
        b     = ref_regs[ins[24:20]];
        f3    = ins[14:12];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        res   = '0;
        wr    = 1'b1;
        stop  = 1'b0;
        npc   = ref_pc + 32'd4;
        case (ins[6:0])
            `OPC_OP:     res = alu(f3, ins[30], a, b);
            `OPC_OP_IMM: res = alu(f3, ins[30] & (f3 == 3'd5), a, imm_i);
            `OPC_LUI:    res = {ins[31:12], 12'b0};
            `OPC_AUIPC:  res = ref_pc + {ins[31:12], 12'b0};
            `OPC_JAL: begin
                res = ref_pc + 32'd4;
                npc = ref_pc + imm_j;
            end
            `OPC_JALR: begin
                res = ref_pc + 32'd4;
                npc = (a + imm_i) & ~32'd1;
            end
            `OPC_BRANCH: begin
                wr = 1'b0;
                if (branch_taken(f3, a, b)) begin
                    npc = ref_pc + imm_b;
                end
            end
            default: begin
                wr          = 1'b0;
                stop        = 1'b1;
                illegal_exp = (ins != EBREAK_WORD);
            end
        endcase
        check_word("commit_pc", commit_pc, ref_pc);
        check_word("commit_we", commit_we, wr);
        if (wr) begin
            check_word("commit_rd", commit_rd, ins[11:7]);
            check_word("commit_data", commit_data, res);
            if (ins[11:7] != 5'd0) begin
                ref_regs[ins[11:7]] = res;
            end
        end
        ref_pc = npc;
        if (stop) begin
            halt_seen = 1'b1;
        end else begin
            fetch_check = 1'b1;
            fetch_addr  = npc;
        end
    endtask

    // Random program with forward-only control flow that ends in ebreak
    task automatic build_program(input int len);
        int          i, kind, off;
        logic [4:0]  rd, rs1, rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] tgt, hi, lo, val;
        logic [12:0] boff;
        logic [20:0] joff;
        prog_len = len;
        for (i = 0; i < PROG_MAX; i++) begin
            prog[i]      = EBREAK_WORD;
            is_target[i] = 1'b0;
        end
        i = 0;
        while (i < len - 1) begin
            rd   = ($urandom_range(7, 0) == 0) ? 5'd0 : 5'($urandom_range(30, 1));
            rs1  = 5'($urandom_range(31, 0));
            rs2  = 5'($urandom_range(31, 0));
            f3   = 3'($urandom_range(7, 0));
            off  = $urandom_range(1, 0) ? 8 : 12;
            val  = $urandom;
            kind = (i < 4) ? 2 : $urandom_range(6, 0);
            if ((kind == 4 || kind == 5) && i + off / 4 > len - 1) begin
                kind = 0;
            end
            if (kind == 6 && (i + 2 + off / 4 > len - 1 || is_target[i + 1]
                              || is_target[i + 2])) begin
                kind = 1;
            end
            f7 = ((f3 == 3'd0 || f3 == 3'd5) && val[0]) ? 7'h20 : 7'h00;
            case (kind)
                0: prog[i] = {f7, rs2, rs1, f3, rd, `OPC_OP};
                1: begin
                    if (f3 == 3'd1 || f3 == 3'd5) begin
                        prog[i] = {(f3 == 3'd5) ? f7 : 7'h00, val[24:20], rs1, f3, rd,
                                   `OPC_OP_IMM};
                    end else begin
                        prog[i] = {val[31:20], rs1, f3, rd, `OPC_OP_IMM};
                    end
                end
                2: prog[i] = {val[31:12], rd, `OPC_LUI};
                3: prog[i] = {val[31:12], rd, `OPC_AUIPC};
                4: begin
                    // Codes 2 and 3 are reserved, so use beq instead
                    if (f3 == 3'd2 || f3 == 3'd3) begin
                        f3 = 3'd0;
                    end
                    if (val[1]) begin
                        rs2 = rs1;
                    end
                    boff = 13'(off);
                    prog[i] = {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11],
                               `OPC_BRANCH};
                    is_target[i + off / 4] = 1'b1;
                end
                5: begin
                    joff = 21'(off);
                    prog[i] = {joff[20], joff[10:1], joff[11], joff[19:12], rd, `OPC_JAL};
                    is_target[i + off / 4] = 1'b1;
                end
                default: begin
                    // x31 is reserved as the jalr base and set right before the jump
                    tgt = (i + 2) * 4 + off;
                    hi  = (tgt + 32'h800) >> 12;
                    lo  = tgt - (hi << 12);
                    prog[i]     = {hi[19:0], 5'd31, `OPC_LUI};
                    prog[i + 1] = {lo[11:0], 5'd31, 3'd0, 5'd31, `OPC_OP_IMM};
                    prog[i + 2] = {12'd0, 5'd31, 3'd0, rd, `OPC_JALR};
                    is_target[tgt >> 2] = 1'b1;
                    i = i + 2;
                end
            endcase
            i++;
        end
    endtask

    // Memory model answers each request after 0 to 3 cycles
    always @(posedge clk) begin
        #1;
        imem_rvalid = 1'b0;
        if (rst) begin
            pending = 1'b0;
        end else if (imem_req) begin
            if (!pending) begin
                pending   = 1'b1;
                wait_left = $urandom_range(3, 0);
            end
            if (wait_left == 0) begin
                imem_rvalid = 1'b1;
                imem_rdata  = mem_word(imem_addr);
                pending     = 1'b0;
            end else begin
                wait_left--;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        (imem_req && !imem_rvalid) |=> (imem_req && $stable(imem_addr)))
        else fail_run("Fetch request dropped or address changed before the response");

    always @(posedge clk) begin
        if (rst) begin
            assert (!commit_valid && !halted && !illegal && !imem_req) else
                fail_run("Core outputs active during reset");
            for (int r = 0; r < 32; r++) begin
                ref_regs[r] = '0;
            end
            ref_pc      = `RESET_PC;
            fetch_check = 1'b1;
            fetch_addr  = `RESET_PC;
            rvalid_seen = 1'b0;
            halt_seen   = 1'b0;
            illegal_exp = 1'b0;
        end else begin
            if (imem_req && fetch_check) begin
                check_word("imem_addr", imem_addr, fetch_addr);
                fetch_check = 1'b0;
            end
            if (imem_rvalid) begin
                rvalid_seen = 1'b1;
            end
            if (commit_valid) begin
                assert (rvalid_seen) else fail_run("Commit without a preceding memory response");
                rvalid_seen = 1'b0;
                step_model();
            end
            if (halted) begin
                assert (!imem_req) else fail_run("Fetch request raised after halt");
            end
        end
    end

    task automatic apply_reset();
        rst = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    task automatic run_program(input logic exp_illegal);
        int cycles;
        apply_reset();
        cycles = 0;
        while (!halted) begin
            @(posedge clk);
            #1;
            cycles++;
            assert (cycles < RUN_TIMEOUT) else fail_run("Timeout waiting for the core to halt");
        end
        repeat (HALT_WINDOW) begin
            @(posedge clk);
            #1;
        end
        assert (halt_seen) else fail_run("Core halted on an instruction that does not halt");
        check_word("halted", halted, 1'b1);
        check_word("illegal", illegal, illegal_exp);
        check_word("illegal", illegal, exp_illegal);
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b0;
        imem_rvalid = 1'b0;
        imem_rdata  = '0;
        void'($urandom(SEED));
        #1;
        build_program(PROG_MAX);
        run_program(1'b0);
        // Every path reaches the last slot, so the load always executes
        build_program(16);
        prog[15] = LOAD_WORD;
        run_program(1'b1);
        $display(">>> PASS");
        $finish;
    end

endmodule

// File: rtl/core_top.sv
`timescale 1ns/10ps
`include "core_defines.svh"

module core_top import core_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    output logic             imem_req,
    output logic [`XLEN-1:0] imem_addr,
    input  logic             imem_rvalid,
    input  logic [`XLEN-1:0] imem_rdata,
    output logic             commit_valid,
    output logic [`XLEN-1:0] commit_pc,
    output logic [4:0]       commit_rd,
    output logic             commit_we,
    output logic [`XLEN-1:0] commit_data,
    output logic             halted,
    output logic             illegal
);

    // Fetch to decode
    logic                 ifu_valid, idu_ready;
    logic [`XLEN-1:0]     if_pc;
    logic [31:0]          if_inst;

    // Decode to execute
    logic                 idu_valid, exu_ready;
    logic [`XLEN-1:0]     id_pc, id_imm;
    logic [4:0]           id_rs1, id_rs2, id_rd;
    logic [`ALU_OP_W-1:0] id_alu_op;
    br_cond_e             id_br_cond;
    logic                 id_src1_is_pc, id_src2_is_imm, id_is_jal, id_is_jalr;
    logic                 id_gpr_we, id_ebreak, id_not_impl;

    // Execute to fetch and register file
    logic                 redirect_valid;
    logic [`XLEN-1:0]     next_pc;
    logic [4:0]           raddr1, raddr2, waddr;
    logic [`XLEN-1:0]     rdata1, rdata2, wdata;
    logic                 we;

    ifu u_ifu (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .next_pc        (next_pc),
        .halted         (halted),
        .imem_req       (imem_req),
        .imem_addr      (imem_addr),
        .imem_rvalid    (imem_rvalid),
        .imem_rdata     (imem_rdata),
        .ifu_valid      (ifu_valid),
        .pc             (if_pc),
        .inst           (if_inst),
        .idu_ready      (idu_ready)
    );

    idu u_idu (
        .clk         (clk),
        .rst         (rst),
        .ifu_valid   (ifu_valid),
        .pc          (if_pc),
        .inst        (if_inst),
        .idu_ready   (idu_ready),
        .idu_valid   (idu_valid),
        .exu_ready   (exu_ready),
        .pc_out      (id_pc),
        .rs1         (id_rs1),
        .rs2         (id_rs2),
        .rd          (id_rd),
        .imm         (id_imm),
        .alu_op      (id_alu_op),
        .br_cond     (id_br_cond),
        .src1_is_pc  (id_src1_is_pc),
        .src2_is_imm (id_src2_is_imm),
        .is_jal      (id_is_jal),
        .is_jalr     (id_is_jalr),
        .gpr_we      (id_gpr_we),
        .ebreak      (id_ebreak),
        .not_impl    (id_not_impl)
    );

    exu u_exu (
        .clk            (clk),
        .rst            (rst),
        .idu_valid      (idu_valid),
        .exu_ready      (exu_ready),
        .pc             (id_pc),
        .rs1            (id_rs1),
        .rs2            (id_rs2),
        .rd             (id_rd),
        .imm            (id_imm),
        .alu_op         (id_alu_op),
        .br_cond        (id_br_cond),
        .src1_is_pc     (id_src1_is_pc),
        .src2_is_imm    (id_src2_is_imm),
        .is_jal         (id_is_jal),
        .is_jalr        (id_is_jalr),
        .gpr_we         (id_gpr_we),
        .ebreak         (id_ebreak),
        .not_impl       (id_not_impl),
        .raddr1         (raddr1),
        .raddr2         (raddr2),
        .rdata1         (rdata1),
        .rdata2         (rdata2),
        .we             (we),
        .waddr          (waddr),
        .wdata          (wdata),
        .redirect_valid (redirect_valid),
        .next_pc        (next_pc),
        .halted         (halted),
        .illegal        (illegal),
        .commit_valid   (commit_valid),
        .commit_pc      (commit_pc),
        .commit_rd      (commit_rd),
        .commit_we      (commit_we),
        .commit_data    (commit_data)
    );

    gpr u_gpr (
        .clk    (clk),
        .rst    (rst),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (we),
        .waddr  (waddr),
        .wdata  (wdata)
    );

endmodule

// File: rtl/exu.sv
`timescale 1ns/10ps
`include "core_defines.svh"

module exu import core_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 idu_valid,
    output logic                 exu_ready,
    input  logic [`XLEN-1:0]     pc,
    input  logic [4:0]           rs1,
    input  logic [4:0]           rs2,
    input  logic [4:0]           rd,
    input  logic [`XLEN-1:0]     imm,
    input  logic [`ALU_OP_W-1:0] alu_op,
    input  br_cond_e             br_cond,
    input  logic                 src1_is_pc,
    input  logic                 src2_is_imm,
    input  logic                 is_jal,
    input  logic                 is_jalr,
    input  logic                 gpr_we,
    input  logic                 ebreak,
    input  logic                 not_impl,
    output logic [4:0]           raddr1,
    output logic [4:0]           raddr2,
    input  logic [`XLEN-1:0]     rdata1,
    input  logic [`XLEN-1:0]     rdata2,
    output logic                 we,
    output logic [4:0]           waddr,
    output logic [`XLEN-1:0]     wdata,
    output logic                 redirect_valid,
    output logic [`XLEN-1:0]     next_pc,
    output logic                 halted,
    output logic                 illegal,
    output logic                 commit_valid,
    output logic [`XLEN-1:0]     commit_pc,
    output logic [4:0]           commit_rd,
    output logic                 commit_we,
    output logic [`XLEN-1:0]     commit_data
);

    logic                 busy;
    logic [`XLEN-1:0]     pc_r, imm_r;
    logic [4:0]           rs1_r, rs2_r, rd_r;
    logic [`ALU_OP_W-1:0] alu_op_r;
    br_cond_e             br_cond_r;
    logic                 src1_is_pc_r, src2_is_imm_r, is_jal_r, is_jalr_r;
    logic                 gpr_we_r, ebreak_r, not_impl_r;
    logic [`XLEN-1:0]     src1, src2, sum, sra_res, alu_res, link, next_pc_c;
    logic [4:0]           shamt;
    logic                 halt, taken;

    always_ff @(posedge clk) begin
        if (idu_valid && !busy) begin
            pc_r          <= pc;
            rs1_r         <= rs1;
            rs2_r         <= rs2;
            rd_r          <= rd;
            imm_r         <= imm;
            alu_op_r      <= alu_op;
            br_cond_r     <= br_cond;
            src1_is_pc_r  <= src1_is_pc;
            src2_is_imm_r <= src2_is_imm;
            is_jal_r      <= is_jal;
            is_jalr_r     <= is_jalr;
            gpr_we_r      <= gpr_we;
            ebreak_r      <= ebreak;
            not_impl_r    <= not_impl;
        end
        if (busy) begin
            next_pc     <= next_pc_c;
            commit_pc   <= pc_r;
            commit_rd   <= rd_r;
            commit_we   <= gpr_we_r & ~halt;
            commit_data <= wdata;
        end
    end

    assign exu_ready = ~busy;
    assign raddr1    = rs1_r;
    assign raddr2    = rs2_r;

    assign src1    = src1_is_pc_r ? pc_r : rdata1;
    assign src2    = src2_is_imm_r ? imm_r : rdata2;
    assign shamt   = src2[4:0];
    assign sum     = src1 + src2;
    assign sra_res = $signed(src1) >>> shamt;

    assign alu_res = ({`XLEN{alu_op_r[ALU_ADD]}}  & sum)
                   | ({`XLEN{alu_op_r[ALU_SUB]}}  & (src1 - src2))
                   | ({`XLEN{alu_op_r[ALU_SLT]}}
                      & {{(`XLEN-1){1'b0}}, $signed(src1) < $signed(src2)})
                   | ({`XLEN{alu_op_r[ALU_SLTU]}} & {{(`XLEN-1){1'b0}}, src1 < src2})
                   | ({`XLEN{alu_op_r[ALU_AND]}}  & (src1 & src2))
                   | ({`XLEN{alu_op_r[ALU_OR]}}   & (src1 | src2))
                   | ({`XLEN{alu_op_r[ALU_XOR]}}  & (src1 ^ src2))
                   | ({`XLEN{alu_op_r[ALU_SLL]}}  & (src1 << shamt))
                   | ({`XLEN{alu_op_r[ALU_SRL]}}  & (src1 >> shamt))
                   | ({`XLEN{alu_op_r[ALU_SRA]}}  & sra_res)
                   | ({`XLEN{alu_op_r[ALU_LUI]}}  & src2);

    // Branches compare the two register values, never the immediate
    always_comb begin
        case (br_cond_r)
            BR_EQ:   taken = (rdata1 == rdata2);
            BR_NE:   taken = (rdata1 != rdata2);
            BR_LT:   taken = ($signed(rdata1) < $signed(rdata2));
            BR_GE:   taken = ($signed(rdata1) >= $signed(rdata2));
            BR_LTU:  taken = (rdata1 < rdata2);
            BR_GEU:  taken = (rdata1 >= rdata2);
            default: taken = 1'b0;
        endcase
    end

    assign halt      = ebreak_r | not_impl_r;
    assign link      = pc_r + `XLEN'd4;
    assign next_pc_c = is_jalr_r ? {sum[`XLEN-1:1], 1'b0} :
                       (is_jal_r || taken) ? sum : link;

    assign we    = busy & gpr_we_r & ~halt;
    assign waddr = rd_r;
    assign wdata = (is_jal_r || is_jalr_r) ? link : alu_res;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy           <= 1'b0;
            commit_valid   <= 1'b0;
            redirect_valid <= 1'b0;
            halted         <= 1'b0;
            illegal        <= 1'b0;
        end else begin
            commit_valid   <= busy;
            redirect_valid <= busy & ~halt;
            if (busy) begin
                busy    <= 1'b0;
                halted  <= halted | halt;
                illegal <= illegal | not_impl_r;
            end else if (idu_valid) begin
                busy <= 1'b1;
            end
        end
    end

endmodule

// File: rtl/idu.sv
`timescale 1ns/10ps
`include "core_defines.svh"

module idu import core_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 ifu_valid,
    input  logic [`XLEN-1:0]     pc,
    input  logic [31:0]          inst,
    output logic                 idu_ready,
    output logic                 idu_valid,
    input  logic                 exu_ready,
    output logic [`XLEN-1:0]     pc_out,
    output logic [4:0]           rs1,
    output logic [4:0]           rs2,
    output logic [4:0]           rd,
    output logic [`XLEN-1:0]     imm,
    output logic [`ALU_OP_W-1:0] alu_op,
    output br_cond_e             br_cond,
    output logic                 src1_is_pc,
    output logic                 src2_is_imm,
    output logic                 is_jal,
    output logic                 is_jalr,
    output logic                 gpr_we,
    output logic                 ebreak,
    output logic                 not_impl
);

    typedef enum logic {IDLE, BUSY} state_e;
    state_e state;

    logic [31:0]        inst_r;
    logic [`XLEN-1:0]   pc_r;
    logic [6:0]         opcode;
    logic [6:0]         funct7;
    logic [7:0]         f3_d;
    logic               op_r, op_i, op_b, f7_0, f7_20;
    logic               inst_add, inst_sub, inst_sll, inst_slt, inst_sltu;
    logic               inst_xor, inst_srl, inst_sra, inst_or, inst_and;
    logic               inst_addi, inst_slti, inst_sltiu, inst_xori, inst_ori;
    logic               inst_andi, inst_slli, inst_srli, inst_srai;
    logic               inst_lui, inst_auipc, inst_jal, inst_jalr, inst_ebreak;
    logic               type_r, type_i, type_u, type_j, type_b;
    logic [`XLEN-1:0]   imm_i, imm_b, imm_u, imm_j;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else if (state == IDLE && ifu_valid) begin
            state <= BUSY;
        end else if (state == BUSY && exu_ready) begin
            state <= IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && ifu_valid) begin
            inst_r <= inst;
            pc_r   <= pc;
        end
    end

    assign idu_ready = (state == IDLE);
    assign idu_valid = (state == BUSY);

    assign opcode = inst_r[6:0];
    assign funct7 = inst_r[31:25];
    assign f3_d   = 8'd1 << inst_r[14:12];
    assign op_r   = (opcode == `OPC_OP);
    assign op_i   = (opcode == `OPC_OP_IMM);
    assign op_b   = (opcode == `OPC_BRANCH);
    assign f7_0   = (funct7 == 7'h00);
    assign f7_20  = (funct7 == 7'h20);

    assign inst_add    = op_r & f3_d[0] & f7_0;
    assign inst_sub    = op_r & f3_d[0] & f7_20;
    assign inst_sll    = op_r & f3_d[1] & f7_0;
    assign inst_slt    = op_r & f3_d[2] & f7_0;
    assign inst_sltu   = op_r & f3_d[3] & f7_0;
    assign inst_xor    = op_r & f3_d[4] & f7_0;
    assign inst_srl    = op_r & f3_d[5] & f7_0;
    assign inst_sra    = op_r & f3_d[5] & f7_20;
    assign inst_or     = op_r & f3_d[6] & f7_0;
    assign inst_and    = op_r & f3_d[7] & f7_0;
    assign inst_addi   = op_i & f3_d[0];
    assign inst_slli   = op_i & f3_d[1] & f7_0;
    assign inst_slti   = op_i & f3_d[2];
    assign inst_sltiu  = op_i & f3_d[3];
    assign inst_xori   = op_i & f3_d[4];
    assign inst_srli   = op_i & f3_d[5] & f7_0;
    assign inst_srai   = op_i & f3_d[5] & f7_20;
    assign inst_ori    = op_i & f3_d[6];
    assign inst_andi   = op_i & f3_d[7];
    assign inst_lui    = (opcode == `OPC_LUI);
    assign inst_auipc  = (opcode == `OPC_AUIPC);
    assign inst_jal    = (opcode == `OPC_JAL);
    assign inst_jalr   = (opcode == `OPC_JALR) & f3_d[0];
    assign inst_ebreak = (inst_r == {12'h001, 13'h0, `OPC_SYSTEM});

    assign type_r = inst_add | inst_sub | inst_sll | inst_slt | inst_sltu
                  | inst_xor | inst_srl | inst_sra | inst_or  | inst_and;
    assign type_i = inst_addi | inst_slti | inst_sltiu | inst_xori | inst_ori
                  | inst_andi | inst_slli | inst_srli  | inst_srai | inst_jalr;
    assign type_u = inst_lui | inst_auipc;
    assign type_j = inst_jal;
    // bltu/bgeu are funct3 6 and 7, codes 2 and 3 are reserved
    assign type_b = op_b & (f3_d[0] | f3_d[1] | f3_d[4] | f3_d[5] | f3_d[6] | f3_d[7]);

    assign imm_i = {{20{inst_r[31]}}, inst_r[31:20]};
    assign imm_b = {{20{inst_r[31]}}, inst_r[7], inst_r[30:25], inst_r[11:8], 1'b0};
    assign imm_u = {inst_r[31:12], 12'b0};
    assign imm_j = {{12{inst_r[31]}}, inst_r[19:12], inst_r[20], inst_r[30:21], 1'b0};

    assign imm = ({`XLEN{type_i}} & imm_i)
               | ({`XLEN{type_b}} & imm_b)
               | ({`XLEN{type_u}} & imm_u)
               | ({`XLEN{type_j}} & imm_j);

    assign alu_op[ALU_ADD]  = inst_add | inst_addi | inst_auipc | inst_jalr;
    assign alu_op[ALU_SUB]  = inst_sub;
    assign alu_op[ALU_SLT]  = inst_slt | inst_slti;
    assign alu_op[ALU_SLTU] = inst_sltu | inst_sltiu;
    assign alu_op[ALU_AND]  = inst_and | inst_andi;
    assign alu_op[ALU_OR]   = inst_or | inst_ori;
    assign alu_op[ALU_XOR]  = inst_xor | inst_xori;
    assign alu_op[ALU_SLL]  = inst_sll | inst_slli;
    assign alu_op[ALU_SRL]  = inst_srl | inst_srli;
    assign alu_op[ALU_SRA]  = inst_sra | inst_srai;
    assign alu_op[ALU_LUI]  = inst_lui;

    always_comb begin
        br_cond = BR_NONE;
        if (type_b) begin
            case (1'b1)
                f3_d[0]: br_cond = BR_EQ;
                f3_d[1]: br_cond = BR_NE;
                f3_d[4]: br_cond = BR_LT;
                f3_d[5]: br_cond = BR_GE;
                f3_d[6]: br_cond = BR_LTU;
                default: br_cond = BR_GEU;
            endcase
        end
    end

    // The adder also forms pc+imm for jal and branch targets
    assign src1_is_pc  = inst_auipc | type_j | type_b;
    assign src2_is_imm = type_i | type_u | type_j | type_b;
    assign gpr_we      = type_r | type_i | type_u | type_j;
    assign is_jal      = inst_jal;
    assign is_jalr     = inst_jalr;
    assign ebreak      = inst_ebreak;
    assign not_impl    = ~(type_r | type_i | type_u | type_j | type_b | inst_ebreak);

    assign pc_out = pc_r;
    assign rs1    = inst_r[19:15];
    assign rs2    = inst_r[24:20];
    assign rd     = inst_r[11:7];

endmodule

// File: rtl/ifu.sv
`timescale 1ns/10ps
`include "core_defines.svh"

module ifu (
    input  logic             clk,
    input  logic             rst,
    input  logic             redirect_valid,
    input  logic [`XLEN-1:0] next_pc,
    input  logic             halted,
    output logic             imem_req,
    output logic [`XLEN-1:0] imem_addr,
    input  logic             imem_rvalid,
    input  logic [`XLEN-1:0] imem_rdata,
    output logic             ifu_valid,
    output logic [`XLEN-1:0] pc,
    output logic [31:0]      inst,
    input  logic             idu_ready
);

    typedef enum logic [1:0] {S_START, S_REQ, S_VALID, S_WAIT} state_e;
    state_e state;

    assign imem_req  = (state == S_REQ);
    assign imem_addr = pc;
    assign ifu_valid = (state == S_VALID);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_START;
            pc    <= `RESET_PC;
        end else begin
            case (state)
                S_START: if (!halted) state <= S_REQ;
                S_REQ: if (imem_rvalid) state <= S_VALID;
                S_VALID: if (idu_ready) state <= S_WAIT;
                // Only one instruction in flight, so wait for exu to resolve the next pc
                S_WAIT: begin
                    if (redirect_valid && !halted) begin
                        pc    <= next_pc;
                        state <= S_REQ;
                    end
                end
                default: state <= S_START;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_REQ && imem_rvalid) begin
            inst <= imem_rdata;
        end
    end

endmodule

// File: rtl/gpr.sv
`timescale 1ns/10ps
`include "core_defines.svh"

module gpr (
    input  logic             clk,
    input  logic             rst,
    input  logic [4:0]       raddr1,
    input  logic [4:0]       raddr2,
    output logic [`XLEN-1:0] rdata1,
    output logic [`XLEN-1:0] rdata2,
    input  logic             we,
    input  logic [4:0]       waddr,
    input  logic [`XLEN-1:0] wdata
);

    logic [`XLEN-1:0] regs [32];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 is never written, so it reads back as zero
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

// File: rtl/core_pkg.sv
package core_pkg;

    // Bit positions inside the one-hot ALU operation vector
    typedef enum int unsigned {
        ALU_ADD  = 0,
        ALU_SUB  = 1,
        ALU_SLT  = 2,
        ALU_SLTU = 3,
        ALU_AND  = 4,
        ALU_OR   = 5,
        ALU_XOR  = 6,
        ALU_SLL  = 7,
        ALU_SRL  = 8,
        ALU_SRA  = 9,
        ALU_LUI  = 10
    } alu_op_e;

    // Branch condition with NONE for anything that is not a branch
    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_EQ   = 3'd1,
        BR_NE   = 3'd2,
        BR_LT   = 3'd3,
        BR_GE   = 3'd4,
        BR_LTU  = 3'd5,
        BR_GEU  = 3'd6
    } br_cond_e;

endpackage

// File: rtl/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Data and address width
`define XLEN 32

// First fetch address after reset
`define RESET_PC 32'h0000_0000

// Major opcodes of the supported RV32I subset
`define OPC_OP     7'h33
`define OPC_OP_IMM 7'h13
`define OPC_LUI    7'h37
`define OPC_AUIPC  7'h17
`define OPC_JAL    7'h6f
`define OPC_JALR   7'h67
`define OPC_BRANCH 7'h63
`define OPC_SYSTEM 7'h73

// Width of the one-hot ALU operation vector
`define ALU_OP_W 11

`endif
